//--- Bender.yml
package:
  name: dispatch

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/dispatchPkg.sv
      - source/renameDispatchLatch.sv
      - source/dispatchSpaceCheck.sv
      - source/dispatchPacketSplit.sv
      - source/dispatchTop.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verif/dispatchChecker.sv
      - verif/dispatchTb.sv

//--- sim.f
+incdir+source
source/dispatchPkg.sv
source/renameDispatchLatch.sv
source/dispatchSpaceCheck.sv
source/dispatchPacketSplit.sv
source/dispatchTop.sv
verif/dispatchChecker.sv
verif/dispatchTb.sv

//--- source/dispatchPacketSplit.sv
// Dispatch packet splitter that forms issue queue, active list and LSQ packets per slot.
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatchPacketSplit (
  input  dispatchPkg::renamedBundle_t latchedBundle_i,
  input  dispatchPkg::ctrlVerify_t    ctrlVerify_i,
  output dispatchPkg::issueBundle_t   issueqBundle_o,
  output dispatchPkg::alBundle_t      alBundle_o,
  output dispatchPkg::lsqBundle_t     lsqBundle_o
);

  import dispatchPkg::*;

  always_comb begin : splitSlots
    branchMask_t slotMask;
    renamedPkt_t pkt;

    for (int slot = 0; slot < `DISPATCH_WIDTH; slot++) begin
      pkt = latchedBundle_i[slot];

      // a branch that verifies in this very cycle must not reach the back end
      // still marked in the mask.
      slotMask = clearVerifiedBit(pkt.branchMask, ctrlVerify_i);

      issueqBundle_o[slot].pc           = pkt.pc;
      issueqBundle_o[slot].opcode       = pkt.opcode;
      issueqBundle_o[slot].immediate    = pkt.immediate;
      issueqBundle_o[slot].phySrc1      = pkt.phySrc1;
      issueqBundle_o[slot].phySrc2      = pkt.phySrc2;
      issueqBundle_o[slot].phyDest      = pkt.phyDest;
      issueqBundle_o[slot].oldPhyDest   = pkt.oldPhyDest;
      issueqBundle_o[slot].hasDest      = pkt.hasDest;
      issueqBundle_o[slot].isLoad       = pkt.isLoad;
      issueqBundle_o[slot].isStore      = pkt.isStore;
      issueqBundle_o[slot].branchMask   = slotMask;
      issueqBundle_o[slot].checkpointId = pkt.checkpointId;

      // the active list keeps both mappings so it can free or restore a tag.
      alBundle_o[slot].isLoad     = pkt.isLoad;
      alBundle_o[slot].isStore    = pkt.isStore;
      alBundle_o[slot].pc         = pkt.pc;
      alBundle_o[slot].logDest    = pkt.logDest;
      alBundle_o[slot].oldPhyDest = pkt.oldPhyDest;
      alBundle_o[slot].phyDest    = pkt.phyDest;
      alBundle_o[slot].hasDest    = pkt.hasDest;

      lsqBundle_o[slot].branchMask = slotMask;
      lsqBundle_o[slot].isStore    = pkt.isStore;
      lsqBundle_o[slot].isLoad     = pkt.isLoad;
    end
  end

endmodule

//--- source/dispatchPkg.sv
// Dispatch package with the renamed and back-end packet formats and mask helper.
`include "dispatch_settings.svh"

package dispatchPkg;

  typedef logic [`CHECKPOINTS-1:0] branchMask_t;

  // one renamed instruction as it leaves the rename stage.
  typedef struct packed {
    logic [`SIZE_PC-1:0]           pc;
    logic [`SIZE_OPCODE-1:0]       opcode;
    logic [`SIZE_IMMEDIATE-1:0]    immediate;
    logic [`SIZE_RMT_LOG-1:0]      logDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [`SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic [`SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] oldPhyDest;
    logic                          hasDest;
    logic                          isLoad;
    logic                          isStore;
    branchMask_t                   branchMask;
    logic [`CHECKPOINTS_LOG-1:0]   checkpointId;
  } renamedPkt_t;

  // issue queue entry; the logical destination stays behind.
  typedef struct packed {
    logic [`SIZE_PC-1:0]           pc;
    logic [`SIZE_OPCODE-1:0]       opcode;
    logic [`SIZE_IMMEDIATE-1:0]    immediate;
    logic [`SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [`SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic [`SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] oldPhyDest;
    logic                          hasDest;
    logic                          isLoad;
    logic                          isStore;
    branchMask_t                   branchMask;
    logic [`CHECKPOINTS_LOG-1:0]   checkpointId;
  } issuePkt_t;

  // active list entry, enough to retire or roll back the mapping.
  typedef struct packed {
    logic                          isLoad;
    logic                          isStore;
    logic [`SIZE_PC-1:0]           pc;
    logic [`SIZE_RMT_LOG-1:0]      logDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] oldPhyDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic                          hasDest;
  } alPkt_t;

  typedef struct packed {
    branchMask_t branchMask;
    logic        isStore;
    logic        isLoad;
  } lsqPkt_t;

  typedef renamedPkt_t [`DISPATCH_WIDTH-1:0] renamedBundle_t;
  typedef issuePkt_t   [`DISPATCH_WIDTH-1:0] issueBundle_t;
  typedef alPkt_t      [`DISPATCH_WIDTH-1:0] alBundle_t;
  typedef lsqPkt_t     [`DISPATCH_WIDTH-1:0] lsqBundle_t;

  // a control instruction resolved correctly and frees its checkpoint.
  typedef struct packed {
    logic                        verified;
    logic [`CHECKPOINTS_LOG-1:0] checkpointId;
  } ctrlVerify_t;

  // drops the verified checkpoint from a branch mask.
  function automatic branchMask_t clearVerifiedBit(branchMask_t mask, ctrlVerify_t verify);
    branchMask_t result;
    result = mask;
    if (verify.verified) begin
      result[verify.checkpointId] = 1'b0;
    end
    return result;
  endfunction

endpackage

//--- source/dispatchSpaceCheck.sv
// Dispatch space check that stalls the front end when a back-end queue would overflow.
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatchSpaceCheck (
  input  dispatchPkg::renamedBundle_t   latchedBundle_i,
  input  logic [`SIZE_LSQ_LOG:0]        loadQueueCnt_i,
  input  logic [`SIZE_LSQ_LOG:0]        storeQueueCnt_i,
  input  logic [`SIZE_ISSUEQ_LOG:0]     issueQueueCnt_i,
  input  logic [`SIZE_ACTIVELIST_LOG:0] activeListCnt_i,
  output logic                          stallFrontEnd_o
);

  import dispatchPkg::*;

  localparam int CNT_W = $clog2(`DISPATCH_WIDTH + 1);

  logic [CNT_W-1:0]                loadCnt;
  logic [CNT_W-1:0]                storeCnt;
  logic [`SIZE_LSQ_LOG+1:0]        loadTotal;
  logic [`SIZE_LSQ_LOG+1:0]        storeTotal;
  logic [`SIZE_ISSUEQ_LOG+1:0]     issueTotal;
  logic [`SIZE_ACTIVELIST_LOG+1:0] alTotal;

  // loads and stores each take one entry in their own half of the LSQ.
  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int slot = 0; slot < `DISPATCH_WIDTH; slot++) begin
      loadCnt  = loadCnt + CNT_W'(latchedBundle_i[slot].isLoad);
      storeCnt = storeCnt + CNT_W'(latchedBundle_i[slot].isStore);
    end
  end

  // sums are one bit wider than the counts, so they cannot wrap.
  assign loadTotal  = (`SIZE_LSQ_LOG+2)'(loadQueueCnt_i) + (`SIZE_LSQ_LOG+2)'(loadCnt);
  assign storeTotal = (`SIZE_LSQ_LOG+2)'(storeQueueCnt_i) + (`SIZE_LSQ_LOG+2)'(storeCnt);

  // every slot needs an issue queue and active list entry, used or not.
  assign issueTotal = (`SIZE_ISSUEQ_LOG+2)'(issueQueueCnt_i)
                    + (`SIZE_ISSUEQ_LOG+2)'(`DISPATCH_WIDTH);
  assign alTotal    = (`SIZE_ACTIVELIST_LOG+2)'(activeListCnt_i)
                    + (`SIZE_ACTIVELIST_LOG+2)'(`DISPATCH_WIDTH);

  assign stallFrontEnd_o = (loadTotal > `SIZE_LSQ)
                         | (storeTotal > `SIZE_LSQ)
                         | (issueTotal > `SIZE_ISSUEQ)
                         | (alTotal > `SIZE_ACTIVELIST);

endmodule

//--- source/dispatchTop.sv
// Dispatch stage top level joining the rename latch, space check and packet splitter.
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatchTop (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic                          renameReady_i,
  input  dispatchPkg::renamedBundle_t   renamedBundle_i,
  input  logic                          flagRecoverEX_i,
  input  dispatchPkg::ctrlVerify_t      ctrlVerify_i,
  input  logic [`SIZE_LSQ_LOG:0]        loadQueueCnt_i,
  input  logic [`SIZE_LSQ_LOG:0]        storeQueueCnt_i,
  input  logic [`SIZE_ISSUEQ_LOG:0]     issueQueueCnt_i,
  input  logic [`SIZE_ACTIVELIST_LOG:0] activeListCnt_i,
  output dispatchPkg::issueBundle_t     issueqBundle_o,
  output dispatchPkg::alBundle_t        alBundle_o,
  output dispatchPkg::lsqBundle_t       lsqBundle_o,
  output logic                          backEndReady_o,
  output logic                          stallFrontEnd_o
);

  import dispatchPkg::*;

  renamedBundle_t latchedBundle;
  logic           latchedValid;
  logic           stallFrontEnd;

  // the bundle leaves when it is valid, fits, and no recovery is under way.
  assign backEndReady_o  = latchedValid & ~stallFrontEnd & ~flagRecoverEX_i;
  assign stallFrontEnd_o = stallFrontEnd;

  renameDispatchLatch latch (
    .clk             (clk),
    .rst_i           (rst_i),
    .renameReady_i   (renameReady_i),
    .renamedBundle_i (renamedBundle_i),
    .dispatchFire_i  (backEndReady_o),
    .flagRecoverEX_i (flagRecoverEX_i),
    .ctrlVerify_i    (ctrlVerify_i),
    .latchedBundle_o (latchedBundle),
    .latchedValid_o  (latchedValid)
  );

  dispatchSpaceCheck spaceCheck (
    .latchedBundle_i (latchedBundle),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .stallFrontEnd_o (stallFrontEnd)
  );

  dispatchPacketSplit packetSplit (
    .latchedBundle_i (latchedBundle),
    .ctrlVerify_i    (ctrlVerify_i),
    .issueqBundle_o  (issueqBundle_o),
    .alBundle_o      (alBundle_o),
    .lsqBundle_o     (lsqBundle_o)
  );

endmodule

//--- source/dispatch_settings.svh
// Dispatch stage settings for widths, slot count and back-end queue sizes.
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// number of instructions renamed and dispatched per cycle.
`define DISPATCH_WIDTH 4

// one mask bit per in-flight branch checkpoint.
`define CHECKPOINTS 8
`define CHECKPOINTS_LOG 3

`define SIZE_PC 32
`define SIZE_OPCODE 8
`define SIZE_IMMEDIATE 16

// logical and physical register tag widths.
`define SIZE_RMT_LOG 5
`define SIZE_PHYSICAL_LOG 7

// back-end queue capacities.
`define SIZE_ISSUEQ 32
`define SIZE_ISSUEQ_LOG 5

`define SIZE_ACTIVELIST 64
`define SIZE_ACTIVELIST_LOG 6

`define SIZE_LSQ 16
`define SIZE_LSQ_LOG 4

`endif

//--- source/renameDispatchLatch.sv
// Rename to dispatch pipeline latch that holds a bundle and keeps its masks current.
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module renameDispatchLatch (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       renameReady_i,
  input  dispatchPkg::renamedBundle_t renamedBundle_i,
  input  logic                       dispatchFire_i,
  input  logic                       flagRecoverEX_i,
  input  dispatchPkg::ctrlVerify_t   ctrlVerify_i,
  output dispatchPkg::renamedBundle_t latchedBundle_o,
  output logic                       latchedValid_o
);

  import dispatchPkg::*;

  renamedBundle_t heldBundle;
  logic           heldValid;
  logic           loadEnable;

  // the latch takes a new bundle when it is empty or its bundle leaves this cycle.
  assign loadEnable = ~heldValid | dispatchFire_i;

  // a recovery squashes whatever is waiting, whether or not it could dispatch.
  always_ff @(posedge clk) begin
    if (rst_i || flagRecoverEX_i) begin
      heldValid <= 1'b0;
    end else if (loadEnable) begin
      heldValid <= renameReady_i;
    end
  end

  // while the bundle waits on back-end space, a branch may resolve.
  // Its checkpoint bit is cleared in place so the bundle no longer depends on it.
  always_ff @(posedge clk) begin
    if (loadEnable) begin
      heldBundle <= renamedBundle_i;
    end else begin
      for (int slot = 0; slot < `DISPATCH_WIDTH; slot++) begin
        heldBundle[slot].branchMask <=
          clearVerifiedBit(heldBundle[slot].branchMask, ctrlVerify_i);
      end
    end
  end

  assign latchedBundle_o = heldBundle;
  assign latchedValid_o  = heldValid;

endmodule

//--- verif/dispatchChecker.sv
// Dispatch checker holding a reference model of the latch, stall rule and packet mapping.
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatchChecker (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic                          renameReady_i,
  input  dispatchPkg::renamedBundle_t   renamedBundle_i,
  input  logic                          flagRecoverEX_i,
  input  dispatchPkg::ctrlVerify_t      ctrlVerify_i,
  input  logic [`SIZE_LSQ_LOG:0]        loadQueueCnt_i,
  input  logic [`SIZE_LSQ_LOG:0]        storeQueueCnt_i,
  input  logic [`SIZE_ISSUEQ_LOG:0]     issueQueueCnt_i,
  input  logic [`SIZE_ACTIVELIST_LOG:0] activeListCnt_i,
  input  dispatchPkg::issueBundle_t     issueqBundle_i,
  input  dispatchPkg::alBundle_t        alBundle_i,
  input  dispatchPkg::lsqBundle_t       lsqBundle_i,
  input  logic                          backEndReady_i,
  input  logic                          stallFrontEnd_i,
  output int                            errorCount_o
);

  import dispatchPkg::*;

  // model of the rename to dispatch latch contents.
  renamedBundle_t modelBundle;
  logic           modelValid = 1'b0;

  int checkCount = 0;
  int errorCount = 0;
  int testChecks = 0;
  int testErrors = 0;
  int testCount  = 0;

  assign errorCount_o = errorCount;

  // a verified checkpoint frees exactly one bit of the mask.
  function automatic branchMask_t maskAfterVerify(branchMask_t mask, ctrlVerify_t verify);
    branchMask_t freed;
    freed = '0;
    if (verify.verified) begin
      freed = branchMask_t'(1) << verify.checkpointId;
    end
    return mask & ~freed;
  endfunction

  // a queue overflows when its count plus the entries the bundle needs exceeds its size.
  function automatic logic expectStall(renamedBundle_t bundle, int loadCnt, int storeCnt,
                                       int issueCnt, int alCnt);
    int loads;
    int stores;
    loads  = 0;
    stores = 0;
    for (int slot = 0; slot < `DISPATCH_WIDTH; slot++) begin
      if (bundle[slot].isLoad) loads++;
      if (bundle[slot].isStore) stores++;
    end
    return (loadCnt + loads > `SIZE_LSQ) || (storeCnt + stores > `SIZE_LSQ)
        || (issueCnt + `DISPATCH_WIDTH > `SIZE_ISSUEQ)
        || (alCnt + `DISPATCH_WIDTH > `SIZE_ACTIVELIST);
  endfunction

  task automatic compareField(string name, logic [127:0] got, logic [127:0] expected);
    checkCount++;
    testChecks++;
    if (got !== expected) begin
      errorCount++;
      testErrors++;
      $display("[ERROR] %0d ns %s got 0x%0h expected 0x%0h", $time, name, got, expected);
    end
  endtask

  task automatic checkOutputs();
    logic        expStall;
    logic        expReady;
    renamedPkt_t pkt;
    branchMask_t expMask;
    issuePkt_t   expIssue;
    alPkt_t      expAl;
    lsqPkt_t     expLsq;
    expStall = expectStall(modelBundle, loadQueueCnt_i, storeQueueCnt_i,
                           issueQueueCnt_i, activeListCnt_i);
    expReady = modelValid & ~expStall & ~flagRecoverEX_i;
    compareField("stallFrontEnd_o", stallFrontEnd_i, expStall);
    compareField("backEndReady_o", backEndReady_i, expReady);
    if (modelValid) begin
      for (int slot = 0; slot < `DISPATCH_WIDTH; slot++) begin
        pkt     = modelBundle[slot];
        expMask = maskAfterVerify(pkt.branchMask, ctrlVerify_i);
        expIssue.pc           = pkt.pc;
        expIssue.opcode       = pkt.opcode;
        expIssue.immediate    = pkt.immediate;
        expIssue.phySrc1      = pkt.phySrc1;
        expIssue.phySrc2      = pkt.phySrc2;
        expIssue.phyDest      = pkt.phyDest;
        expIssue.oldPhyDest   = pkt.oldPhyDest;
        expIssue.hasDest      = pkt.hasDest;
        expIssue.isLoad       = pkt.isLoad;
        expIssue.isStore      = pkt.isStore;
        expIssue.branchMask   = expMask;
        expIssue.checkpointId = pkt.checkpointId;
        expAl.isLoad          = pkt.isLoad;
        expAl.isStore         = pkt.isStore;
        expAl.pc              = pkt.pc;
        expAl.logDest         = pkt.logDest;
        expAl.oldPhyDest      = pkt.oldPhyDest;
        expAl.phyDest         = pkt.phyDest;
        expAl.hasDest         = pkt.hasDest;
        expLsq.branchMask     = expMask;
        expLsq.isStore        = pkt.isStore;
        expLsq.isLoad         = pkt.isLoad;
        compareField($sformatf("issueqBundle_o[%0d]", slot), issueqBundle_i[slot], expIssue);
        compareField($sformatf("alBundle_o[%0d]", slot), alBundle_i[slot], expAl);
        compareField($sformatf("lsqBundle_o[%0d]", slot), lsqBundle_i[slot], expLsq);
      end
    end
  endtask

  // inputs are stable at the falling edge, so the check and the next model state
  // are both taken here.
  always @(negedge clk) begin : modelStep
    logic stall;
    logic loadNow;
    if (!rst_i) begin
      checkOutputs();
    end
    stall   = expectStall(modelBundle, loadQueueCnt_i, storeQueueCnt_i,
                          issueQueueCnt_i, activeListCnt_i);
    loadNow = !modelValid || (modelValid && !stall && !flagRecoverEX_i);
    if (loadNow) begin
      modelBundle = renamedBundle_i;
    end else begin
      for (int slot = 0; slot < `DISPATCH_WIDTH; slot++) begin
        modelBundle[slot].branchMask = maskAfterVerify(modelBundle[slot].branchMask,
                                                       ctrlVerify_i);
      end
    end
    if (rst_i || flagRecoverEX_i) begin
      modelValid = 1'b0;
    end else if (loadNow) begin
      modelValid = renameReady_i;
    end
  end

  task automatic finishTest(string name, int otherFailures);
    testCount++;
    $display("test %0d %s: %0d checks, %0d mismatches, %0d other failures, %s",
             testCount, name, testChecks, testErrors, otherFailures,
             (testErrors + otherFailures == 0) ? "ok" : "failed");
    testChecks = 0;
    testErrors = 0;
  endtask

  task automatic printTotals(int otherFailures);
    $display("totals: %0d tests, %0d checks, %0d mismatches, %0d other failures",
             testCount, checkCount, errorCount, otherFailures);
  endtask

endmodule

//--- verif/dispatchTb.sv
// Dispatch stage testbench driving random bundles, queue counts and branch events.
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatchTb;

  import dispatchPkg::*;

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 5;
  localparam int WAIT_LIMIT     = 20;
  localparam int IDLE_CYCLES    = 6;
  localparam int FLOW_CYCLES    = 40;
  localparam int SWEEP_HOLD     = 3;
  localparam int STALL_VERIFIES = 12;
  localparam int FLOW_VERIFIES  = 20;

  // cycle budget of each test, used by the watchdog.
  localparam int TEST1_CYCLES   = IDLE_CYCLES + 3 + WAIT_LIMIT;
  localparam int TEST2_CYCLES   = FLOW_CYCLES + 1;
  localparam int TEST3_CYCLES   = 4 * (5 * SWEEP_HOLD + 1 + WAIT_LIMIT) + 1;
  localparam int TEST4_CYCLES   = STALL_VERIFIES + FLOW_VERIFIES + 3 + WAIT_LIMIT;
  localparam int TEST5_CYCLES   = 16 + WAIT_LIMIT;
  localparam int TOTAL_CYCLES   = RESET_CYCLES + TEST1_CYCLES + TEST2_CYCLES + TEST3_CYCLES
                                + TEST4_CYCLES + TEST5_CYCLES;
  localparam int MARGIN_CYCLES  = 100;

  localparam ctrlVerify_t NO_VERIFY = '0;

  logic                          clk;
  logic                          rst;
  logic                          renameReady;
  renamedBundle_t                renamedBundle;
  logic                          flagRecoverEX;
  ctrlVerify_t                   ctrlVerify;
  logic [`SIZE_LSQ_LOG:0]        loadQueueCnt;
  logic [`SIZE_LSQ_LOG:0]        storeQueueCnt;
  logic [`SIZE_ISSUEQ_LOG:0]     issueQueueCnt;
  logic [`SIZE_ACTIVELIST_LOG:0] activeListCnt;
  issueBundle_t                  issueqBundle;
  alBundle_t                     alBundle;
  lsqBundle_t                    lsqBundle;
  logic                          backEndReady;
  logic                          stallFrontEnd;

  int          errorCount;
  int          otherFailures  = 0;
  int          testFailures   = 0;
  int          stallCycles    = 0;
  int          dispatchCycles = 0;
  logic [31:0] lcgState;

  dispatchTop uut (
    .clk             (clk),
    .rst_i           (rst),
    .renameReady_i   (renameReady),
    .renamedBundle_i (renamedBundle),
    .flagRecoverEX_i (flagRecoverEX),
    .ctrlVerify_i    (ctrlVerify),
    .loadQueueCnt_i  (loadQueueCnt),
    .storeQueueCnt_i (storeQueueCnt),
    .issueQueueCnt_i (issueQueueCnt),
    .activeListCnt_i (activeListCnt),
    .issueqBundle_o  (issueqBundle),
    .alBundle_o      (alBundle),
    .lsqBundle_o     (lsqBundle),
    .backEndReady_o  (backEndReady),
    .stallFrontEnd_o (stallFrontEnd)
  );

  dispatchChecker outputCheck (
    .clk             (clk),
    .rst_i           (rst),
    .renameReady_i   (renameReady),
    .renamedBundle_i (renamedBundle),
    .flagRecoverEX_i (flagRecoverEX),
    .ctrlVerify_i    (ctrlVerify),
    .loadQueueCnt_i  (loadQueueCnt),
    .storeQueueCnt_i (storeQueueCnt),
    .issueQueueCnt_i (issueQueueCnt),
    .activeListCnt_i (activeListCnt),
    .issueqBundle_i  (issueqBundle),
    .alBundle_i      (alBundle),
    .lsqBundle_i     (lsqBundle),
    .backEndReady_i  (backEndReady),
    .stallFrontEnd_i (stallFrontEnd),
    .errorCount_o    (errorCount)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(negedge clk) begin
    if (!rst && stallFrontEnd) stallCycles++;
    if (!rst && backEndReady) dispatchCycles++;
  end

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic renamedBundle_t randomBundle();
    renamedBundle_t bundle;
    logic [31:0]    word;
    for (int slot = 0; slot < `DISPATCH_WIDTH; slot++) begin
      bundle[slot].pc           = nextRandom();
      word                      = nextRandom();
      bundle[slot].opcode       = word[7:0];
      bundle[slot].immediate    = word[23:8];
      bundle[slot].logDest      = word[28:24];
      word                      = nextRandom();
      bundle[slot].phySrc1      = word[6:0];
      bundle[slot].phySrc2      = word[13:7];
      bundle[slot].phyDest      = word[20:14];
      bundle[slot].oldPhyDest   = word[27:21];
      bundle[slot].hasDest      = word[28];
      bundle[slot].isLoad       = word[29];
      bundle[slot].isStore      = word[30];
      word                      = nextRandom();
      bundle[slot].branchMask   = word[7:0];
      bundle[slot].checkpointId = word[10:8];
    end
    return bundle;
  endfunction

  // a resolved branch with a random checkpoint.
  function automatic ctrlVerify_t forcedVerify();
    ctrlVerify_t verify;
    logic [31:0] word;
    word                = nextRandom();
    verify.verified     = 1'b1;
    verify.checkpointId = word[`CHECKPOINTS_LOG-1:0];
    return verify;
  endfunction

  task automatic driveCycle(logic ready, logic recover, ctrlVerify_t verify,
                            int loadCnt, int storeCnt, int issueCnt, int alCnt);
    @(posedge clk);
    renameReady   <= ready;
    renamedBundle <= randomBundle();
    flagRecoverEX <= recover;
    ctrlVerify    <= verify;
    loadQueueCnt  <= loadCnt[`SIZE_LSQ_LOG:0];
    storeQueueCnt <= storeCnt[`SIZE_LSQ_LOG:0];
    issueQueueCnt <= issueCnt[`SIZE_ISSUEQ_LOG:0];
    activeListCnt <= alCnt[`SIZE_ACTIVELIST_LOG:0];
  endtask

  // counts low enough that a full bundle always fits.
  task automatic driveFreeCycle(logic ready, ctrlVerify_t verify);
    driveCycle(ready, 1'b0, verify,
               int'(nextRandom() % (`SIZE_LSQ - `DISPATCH_WIDTH + 1)),
               int'(nextRandom() % (`SIZE_LSQ - `DISPATCH_WIDTH + 1)),
               int'(nextRandom() % (`SIZE_ISSUEQ - `DISPATCH_WIDTH + 1)),
               int'(nextRandom() % (`SIZE_ACTIVELIST - `DISPATCH_WIDTH + 1)));
  endtask

  // one queue sits near its overflow point, the others stay nearly empty.
  task automatic sweepCycle(int queue, int offset);
    int lq;
    int sq;
    int iq;
    int al;
    lq = 1;
    sq = 1;
    iq = 2;
    al = 3;
    case (queue)
      0:       lq = `SIZE_LSQ - 2 + offset;
      1:       sq = `SIZE_LSQ - 2 + offset;
      2:       iq = `SIZE_ISSUEQ - `DISPATCH_WIDTH + offset;
      default: al = `SIZE_ACTIVELIST - `DISPATCH_WIDTH + offset;
    endcase
    driveCycle(1'b1, 1'b0, NO_VERIFY, lq, sq, iq, al);
  endtask

  task automatic waitForDispatch(string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!backEndReady && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!backEndReady) begin
      $display("%s: backEndReady_o did not rise within %0d cycles", what, WAIT_LIMIT);
      testFailures++;
    end
  endtask

  task automatic closeTest(string name);
    outputCheck.finishTest(name, testFailures);
    otherFailures += testFailures;
    testFailures = 0;
  endtask

  initial begin
    #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog expired after %0d cycles with tests still running",
             TOTAL_CYCLES + MARGIN_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : stimulus
    int stallBefore;
    int dispatchBefore;
    lcgState      = 32'h9b4bb0a2;
    rst           = 1'b1;
    renameReady   = 1'b0;
    renamedBundle = '0;
    flagRecoverEX = 1'b0;
    ctrlVerify    = '0;
    loadQueueCnt  = '0;
    storeQueueCnt = '0;
    issueQueueCnt = '0;
    activeListCnt = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // nothing is offered at first, so the stage must stay idle.
    repeat (IDLE_CYCLES) driveFreeCycle(1'b0, NO_VERIFY);
    driveFreeCycle(1'b1, NO_VERIFY);
    driveFreeCycle(1'b0, NO_VERIFY);
    waitForDispatch("test 1");
    driveFreeCycle(1'b0, NO_VERIFY);
    closeTest("reset and first dispatch");

    dispatchBefore = dispatchCycles;
    repeat (FLOW_CYCLES) driveFreeCycle(1'b1, NO_VERIFY);
    driveFreeCycle(1'b0, NO_VERIFY);
    if (dispatchCycles - dispatchBefore < FLOW_CYCLES - 1) begin
      $display("test 2: only %0d of %0d bundles dispatched in free flow",
               dispatchCycles - dispatchBefore, FLOW_CYCLES);
      testFailures++;
    end
    closeTest("free flow");

    stallBefore = stallCycles;
    for (int queue = 0; queue < 4; queue++) begin
      for (int offset = -2; offset <= 2; offset++) begin
        repeat (SWEEP_HOLD) sweepCycle(queue, offset);
      end
      driveFreeCycle(1'b0, NO_VERIFY);
      waitForDispatch("test 3");
    end
    driveFreeCycle(1'b0, NO_VERIFY);
    if (stallCycles == stallBefore) begin
      $display("test 3: the threshold sweep never stalled the front end");
      testFailures++;
    end
    closeTest("queue thresholds");

    // the issue queue is full, so the bundle waits while branches resolve.
    driveFreeCycle(1'b1, NO_VERIFY);
    repeat (STALL_VERIFIES) begin
      driveCycle(1'b1, 1'b0, forcedVerify(), 0, 0, `SIZE_ISSUEQ, 0);
    end
    driveFreeCycle(1'b0, NO_VERIFY);
    waitForDispatch("test 4");
    repeat (FLOW_VERIFIES) driveFreeCycle(1'b1, forcedVerify());
    driveFreeCycle(1'b0, NO_VERIFY);
    closeTest("branch verify");

    repeat (4) driveFreeCycle(1'b1, NO_VERIFY);
    driveCycle(1'b1, 1'b1, NO_VERIFY, 0, 0, 0, 0);
    driveFreeCycle(1'b0, NO_VERIFY);
    @(negedge clk);
    if (backEndReady) begin
      $display("test 5: the latch still held a bundle after a recovery");
      testFailures++;
    end
    // a recovery must also squash a bundle that is stalled.
    repeat (3) driveCycle(1'b1, 1'b0, NO_VERIFY, 0, 0, `SIZE_ISSUEQ, 0);
    driveCycle(1'b1, 1'b1, NO_VERIFY, 0, 0, `SIZE_ISSUEQ, 0);
    repeat (2) driveFreeCycle(1'b0, NO_VERIFY);
    driveFreeCycle(1'b1, NO_VERIFY);
    driveFreeCycle(1'b0, NO_VERIFY);
    waitForDispatch("test 5");
    driveFreeCycle(1'b0, NO_VERIFY);
    closeTest("recovery");

    outputCheck.printTotals(otherFailures);
    if (errorCount == 0 && otherFailures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
